// File: project.f
rtl/ifu_pkg.sv
rtl/ifu_queue_if.sv
rtl/ifu_fetch_ctrl.sv
rtl/ifu_instr_queue.sv
rtl/ifu_top.sv
sim/imem_model.sv
sim/ifu_tb.sv

// File: Makefile
# Verilator build and run of the fetch unit testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, check the log for the pass message"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module ifu_tb \
		-f project.f -o ifu_tb
	./obj_dir/ifu_tb | tee $(LOG)
	grep -q "Finished with no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: sim/ifu_tb.sv
/* Testbench for the fetch unit: clock, reset, stimulus,
   reference stream parser, port assertions and watchdog */

`timescale 1ns/100ps

module ifu_tb;
    import ifu_pkg::*;

    localparam int N_TESTS = 6;

    logic            clk;
    logic            rst_n;
    logic            pipe_stop_fetch_i;
    logic            exu_pc_new_req_i;
    logic [XLEN-1:0] exu_pc_new_i;
    logic            imem_req;
    logic [XLEN-1:0] imem_addr;
    logic            imem_ack;
    logic [XLEN-1:0] imem_rdata;
    mem_resp_e       imem_resp;
    logic            idu_rdy_i;
    logic            idu_vd_o;
    logic [XLEN-1:0] idu_instr_o;
    logic            idu_imem_err_o;
    logic            idu_err_rvi_hi_o;

    integer          seed;
    int              errors;
    logic            rdy_raw;           // Ready before the hold
    logic            hold_rdy;          // No consume on redirect cycles or after a stop
    logic            rnd_rdy;
    logic            restart;
    logic            no_pc_yet;         // Fetch must stay quiet
    logic [XLEN-1:0] next_addr;

    // Expected stream
    logic [XLEN-1:0] exp_instr [64];
    logic            exp_err   [64];
    logic            exp_hi    [64];
    int              exp_cnt;
    int              exp_rd;

    wire consume = idu_vd_o & idu_rdy_i;
    wire mem_hs  = imem_req & imem_ack;

    assign idu_rdy_i = rdy_raw & ~hold_rdy;

    ifu_top dut_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .pipe_stop_fetch_i(pipe_stop_fetch_i),
        .exu_pc_new_req_i (exu_pc_new_req_i),
        .exu_pc_new_i     (exu_pc_new_i),
        .imem_req_o       (imem_req),
        .imem_addr_o      (imem_addr),
        .imem_ack_i       (imem_ack),
        .imem_rdata_i     (imem_rdata),
        .imem_resp_i      (imem_resp),
        .idu_rdy_i        (idu_rdy_i),
        .idu_vd_o         (idu_vd_o),
        .idu_instr_o      (idu_instr_o),
        .idu_imem_err_o   (idu_imem_err_o),
        .idu_err_rvi_hi_o (idu_err_rvi_hi_o)
    );

    imem_model #(.SEED(93)) mem_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .req_i  (imem_req),
        .addr_i (imem_addr),
        .ack_o  (imem_ack),
        .resp_o (imem_resp),
        .rdata_o(imem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // --------------------
    // Scoreboard state
    // --------------------

    always @(posedge clk) begin
        if (restart) exp_rd <= 0;
        else if (consume) exp_rd <= exp_rd + 1;
        if (exu_pc_new_req_i) begin
            next_addr <= {exu_pc_new_i[XLEN-1:2], 2'b00} + (mem_hs ? 32'd4 : 32'd0);
        end else if (mem_hs) begin
            next_addr <= next_addr + 32'd4;
        end
    end

    always @(negedge clk) begin
        rdy_raw = rnd_rdy ? $random(seed) : 1'b1;
    end

    // --------------------
    // Port assertions
    // --------------------

    a_instr: assert property (@(posedge clk) disable iff (!rst_n)
        consume |-> exp_rd < exp_cnt && idu_instr_o == exp_instr[exp_rd]
                    && idu_imem_err_o == exp_err[exp_rd] && idu_err_rvi_hi_o == exp_hi[exp_rd])
        else begin
            errors++;
            $display("error %0t: instr %h err %b hi %b, expected entry %0d of %0d", $time,
                     idu_instr_o, idu_imem_err_o, idu_err_rvi_hi_o, exp_rd, exp_cnt);
        end

    a_rvc_zero: assert property (@(posedge clk) disable iff (!rst_n)
        consume && idu_instr_o[1:0] != 2'b11 |-> idu_instr_o[31:16] == 16'h0)
        else begin
            errors++;
            $display("error %0t: compressed upper half not zero", $time);
        end

    a_addr_align: assert property (@(posedge clk) disable iff (!rst_n)
        imem_req |-> imem_addr[1:0] == 2'b00)
        else begin
            errors++;
            $display("error %0t: address %h unaligned", $time, imem_addr);
        end

    // Redirect word first, then one word further per accepted request
    a_addr_step: assert property (@(posedge clk) disable iff (!rst_n)
        mem_hs |-> imem_addr == (exu_pc_new_req_i ? {exu_pc_new_i[XLEN-1:2], 2'b00}
                                                  : next_addr))
        else begin
            errors++;
            $display("error %0t: address %h out of sequence", $time, imem_addr);
        end

    a_hi_needs_err: assert property (@(posedge clk) disable iff (!rst_n)
        idu_err_rvi_hi_o |-> idu_imem_err_o)
        else begin
            errors++;
            $display("error %0t: upper-half flag without fault", $time);
        end

    a_no_req_after_err: assert property (@(posedge clk) disable iff (!rst_n)
        idu_vd_o && idu_imem_err_o && !exu_pc_new_req_i |-> !imem_req)
        else begin
            errors++;
            $display("error %0t: request after access fault", $time);
        end

    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        idu_vd_o && !idu_rdy_i && !pipe_stop_fetch_i && !exu_pc_new_req_i
        |=> idu_vd_o && $stable(idu_instr_o))
        else begin
            errors++;
            $display("error %0t: output changed under back-pressure", $time);
        end

    a_stop: assert property (@(posedge clk) disable iff (!rst_n)
        pipe_stop_fetch_i |=> !idu_vd_o && !imem_req)
        else begin
            errors++;
            $display("error %0t: activity after stop", $time);
        end

    a_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        no_pc_yet |-> !idu_vd_o && !imem_req)
        else begin
            errors++;
            $display("error %0t: activity before first new PC", $time);
        end

    // --------------------
    // Reference parser
    // --------------------

    task automatic add_entry(input logic [XLEN-1:0] instr, input logic err, input logic hi);
        exp_instr[exp_cnt] = instr;
        exp_err[exp_cnt]   = err;
        exp_hi[exp_cnt]    = hi;
        exp_cnt++;
    endtask

    // Halfword walk from pc, a fault ends the stream after the rest of its word
    task automatic parse_stream(input logic [XLEN-1:0] pc);
        int          h;
        int          h2;
        logic [15:0] p;
        logic [15:0] p2;
        h = int'(pc[7:1]);
        exp_cnt = 0;
        while (exp_cnt < 48) begin
            p = h[0] ? mem_i.image[h >> 1][31:16] : mem_i.image[h >> 1][15:0];
            if (mem_i.err_map[h >> 1]) begin
                add_entry({16'h0, p}, 1'b1, 1'b0);
                if (!h[0]) add_entry({16'h0, mem_i.image[h >> 1][31:16]}, 1'b1, 1'b0);
                break;
            end
            if (p[1:0] != 2'b11) begin
                add_entry({16'h0, p}, 1'b0, 1'b0);
                h = (h + 1) % 128;
            end else begin
                h2 = (h + 1) % 128;
                p2 = h2[0] ? mem_i.image[h2 >> 1][31:16] : mem_i.image[h2 >> 1][15:0];
                if (mem_i.err_map[h2 >> 1]) begin
                    add_entry({p2, p}, 1'b1, 1'b1);
                    if (!h2[0]) add_entry({16'h0, mem_i.image[h2 >> 1][31:16]}, 1'b1, 1'b0);
                    break;
                end
                add_entry({p2, p}, 1'b0, 1'b0);
                h = (h + 2) % 128;
            end
        end
    endtask

    // --------------------
    // Stimulus helpers
    // --------------------

    task automatic redirect(input logic [XLEN-1:0] pc);
        parse_stream(pc);
        exu_pc_new_i     = pc;
        exu_pc_new_req_i = 1'b1;
        hold_rdy         = 1'b1;
        restart          = 1'b1;
        no_pc_yet        = 1'b0;
        @(negedge clk);
        exu_pc_new_req_i = 1'b0;
        hold_rdy         = 1'b0;
        restart          = 1'b0;
    endtask

    task automatic wait_instr(input int n);
        int t;
        t = 0;
        if (n > exp_cnt) n = exp_cnt;
        while (exp_rd < n && t < 1000) begin
            @(negedge clk);
            t++;
        end
        if (exp_rd < n) begin
            errors++;
            $display("only %0d of %0d instructions arrived in time", exp_rd, n);
        end
    endtask

    task automatic report_test(input int num, input string name, input int errs_before);
        $display("test %0d %s: %0d errors", num, name, errors - errs_before);
    endtask

    initial begin
        #(N_TESTS * 2000);
        $display("watchdog expired before the tests completed");
        $display("Finished with errors");
        $finish;
    end

    initial begin
        int e0;
        seed = 93;
        errors = 0;
        rst_n = 1'b0;
        pipe_stop_fetch_i = 1'b0;
        exu_pc_new_req_i = 1'b0;
        exu_pc_new_i = '0;
        rdy_raw = 1'b1;
        hold_rdy = 1'b0;
        rnd_rdy = 1'b0;
        restart = 1'b0;
        no_pc_yet = 1'b1;
        exp_cnt = 0;
        exp_rd = 0;
        next_addr = '0;
        for (int i = 0; i < 64; i++) mem_i.image[i] = $random(seed) | 32'h0003_0003;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        repeat (3) @(negedge clk);

        e0 = errors;                                // Full instructions only
        redirect(32'h0);
        wait_instr(20);
        report_test(1, "aligned stream", e0);

        e0 = errors;
        for (int i = 0; i < 64; i++) mem_i.image[i] = $random(seed);
        redirect(32'h0);
        wait_instr(20);
        report_test(2, "mixed parcels", e0);

        e0 = errors;
        redirect(32'h0);
        wait_instr(3);
        redirect(32'h22);                           // Upper parcel of word 8
        wait_instr(15);
        report_test(3, "redirect", e0);

        e0 = errors;
        mem_i.image[9][1:0]   = 2'b01;              // Compressed, then straddle into word 10
        mem_i.image[9][17:16] = 2'b11;
        mem_i.err_map[10]     = 1'b1;
        redirect(32'h24);
        wait_instr(exp_cnt);
        redirect(32'h28);
        wait_instr(exp_cnt);
        repeat (5) @(negedge clk);
        mem_i.err_map[10] = 1'b0;
        report_test(4, "access fault", e0);

        e0 = errors;
        rnd_rdy = 1'b1;
        redirect(32'h0);
        wait_instr(20);
        rnd_rdy = 1'b0;
        report_test(5, "back-pressure", e0);

        e0 = errors;
        redirect(32'h0);
        wait_instr(4);
        pipe_stop_fetch_i = 1'b1;
        hold_rdy = 1'b1;                            // Late responses of the old stream stay put
        @(negedge clk);
        pipe_stop_fetch_i = 1'b0;
        repeat (10) @(negedge clk);
        rst_n = 1'b0;
        no_pc_yet = 1'b1;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        hold_rdy = 1'b0;
        repeat (20) @(negedge clk);
        report_test(6, "stop and reset", e0);

        $display("tests %0d, errors %0d", N_TESTS, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule : ifu_tb

// File: sim/imem_model.sv
/* Instruction memory model with a word image, an error map,
   random ack delay and in-order responses of random latency */

`timescale 1ns/100ps

module imem_model #(
    parameter int SEED = 93
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     req_i,
    input  logic [ifu_pkg::XLEN-1:0] addr_i,
    output logic                     ack_o,
    output ifu_pkg::mem_resp_e       resp_o,
    output logic [ifu_pkg::XLEN-1:0] rdata_o
);
    import ifu_pkg::*;

    logic [XLEN-1:0] image   [64];      // Word image, index is addr[7:2]
    logic            err_map [64];      // Words that answer with a fault
    integer          seed;
    logic            ack_en;
    int              cyc;
    int              last_due;
    int              due_q [$];         // Cycle from which each response may go out
    logic [5:0]      idx_q [$];

    initial begin
        seed   = SEED;
        ack_en = 1'b0;
        resp_o = MEM_RESP_NOTRDY;
        rdata_o = '0;
        for (int i = 0; i < 64; i++) begin
            err_map[i] = 1'b0;
        end
    end

    assign ack_o = req_i & ack_en;

    // --------------------
    // Accept and retire
    // --------------------

    always @(posedge clk or negedge rst_n) begin
        int lat;
        int due;
        if (!rst_n) begin
            due_q.delete();
            idx_q.delete();
            cyc      = 0;
            last_due = 0;
        end else begin
            cyc = cyc + 1;
            if (resp_o != MEM_RESP_NOTRDY) begin   // DUT took the head response
                void'(due_q.pop_front());
                void'(idx_q.pop_front());
            end
            if (req_i && ack_o) begin
                lat = 1 + ($unsigned($random(seed)) % 3);   // 1 to 3 cycles
                due = cyc + lat - 1;
                if (due <= last_due) due = last_due + 1;   // Keep order
                last_due = due;
                due_q.push_back(due);
                idx_q.push_back(addr_i[7:2]);
            end
        end
    end

    // Outputs change on the falling edge
    always @(negedge clk) begin
        ack_en = ($random(seed) & 3) != 0;          // Ack about 3 of 4 cycles
        if (rst_n && due_q.size() > 0 && due_q[0] <= cyc) begin
            resp_o  = err_map[idx_q[0]] ? MEM_RESP_RDY_ER : MEM_RESP_RDY_OK;
            rdata_o = image[idx_q[0]];
        end else begin
            resp_o  = MEM_RESP_NOTRDY;
            rdata_o = '0;
        end
    end

endmodule : imem_model

// File: rtl/ifu_top.sv
/* Instruction fetch unit top level with plain ports */

`timescale 1ns/100ps

module ifu_top #(
    parameter int Q_WORDS   = ifu_pkg::Q_WORDS_DEF,     // Queue depth in words
    parameter int TXN_CNT_W = ifu_pkg::TXN_CNT_W_DEF    // Outstanding limit is 2**W-1
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     pipe_stop_fetch_i,     // Pipeline stop
    // Redirect from execute
    input  logic                     exu_pc_new_req_i,
    input  logic [ifu_pkg::XLEN-1:0] exu_pc_new_i,
    // Instruction memory
    output logic                     imem_req_o,
    output logic [ifu_pkg::XLEN-1:0] imem_addr_o,           // Word aligned
    input  logic                     imem_ack_i,
    input  logic [ifu_pkg::XLEN-1:0] imem_rdata_i,
    input  ifu_pkg::mem_resp_e       imem_resp_i,
    // Decode
    input  logic                     idu_rdy_i,
    output logic                     idu_vd_o,
    output logic [ifu_pkg::XLEN-1:0] idu_instr_o,
    output logic                     idu_imem_err_o,
    output logic                     idu_err_rvi_hi_o
);
    import ifu_pkg::*;

    imem_word_u imem_rdata_w;

    ifu_queue_if #(.Q_WORDS(Q_WORDS)) q_if ();

    // Raw bus word into the two-view type
    assign imem_rdata_w.instr = imem_rdata_i;

    // --------------------
    // Memory side
    // --------------------

    ifu_fetch_ctrl #(
        .TXN_CNT_W        (TXN_CNT_W)
    ) ctrl_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .pipe_stop_fetch_i(pipe_stop_fetch_i),
        .exu_pc_new_req_i (exu_pc_new_req_i),
        .exu_pc_new_i     (exu_pc_new_i),
        .imem_ack_i       (imem_ack_i),
        .imem_resp_i      (imem_resp_i),
        .imem_rdata_i     (imem_rdata_w),
        .imem_req_o       (imem_req_o),
        .imem_addr_o      (imem_addr_o),
        .q                (q_if.ctrl)
    );

    // --------------------
    // Decode side
    // --------------------

    ifu_instr_queue #(
        .Q_WORDS          (Q_WORDS)
    ) queue_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .idu_rdy_i        (idu_rdy_i),
        .idu_vd_o         (idu_vd_o),
        .idu_instr_o      (idu_instr_o),
        .idu_imem_err_o   (idu_imem_err_o),
        .idu_err_rvi_hi_o (idu_err_rvi_hi_o),
        .q                (q_if.queue)
    );

endmodule : ifu_top

// File: rtl/ifu_instr_queue.sv
/* Parcel type decoder, halfword queue with pointers and the
   instruction output toward decode */

`timescale 1ns/100ps

module ifu_instr_queue #(
    parameter int Q_WORDS = ifu_pkg::Q_WORDS_DEF
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     idu_rdy_i,             // Decode takes the head
    output logic                     idu_vd_o,
    output logic [ifu_pkg::XLEN-1:0] idu_instr_o,
    output logic                     idu_imem_err_o,        // Access fault
    output logic                     idu_err_rvi_hi_o,      // Fault on upper half
    ifu_queue_if.queue               q
);
    import ifu_pkg::*;

    localparam int Q_HALFS  = Q_WORDS * 2;
    localparam int ADR_W    = $clog2(Q_HALFS);
    localparam int PTR_W    = ADR_W + 1;                    // Extra wrap bit
    localparam int FREE_H_W = $clog2(Q_HALFS + 1);
    localparam int FREE_W_W = $clog2(Q_WORDS + 1);

    // Pattern names are <upper parcel>_<lower parcel>
    typedef enum logic [2:0] {
        INSTR_NONE,
        INSTR_RVI_HI_RVI_LO,        // Aligned full instruction
        INSTR_RVC_RVC,
        INSTR_RVI_LO_RVC,
        INSTR_RVC_RVI_HI,
        INSTR_RVI_LO_RVI_HI,
        INSTR_RVC_NV,               // Unaligned start, low parcel unused
        INSTR_RVI_LO_NV
    } parcel_type_e;

    logic                unaligned_ff;
    logic                straddle_ff;      // Previous word ended in a full instr low half
    logic                straddle_next;
    logic                hi_is_rvi;
    logic                lo_is_rvi;
    parcel_type_e        instr_type;

    logic                q_wr_en;
    logic                q_wr_hi;
    logic                q_wr_full;
    logic                q_rd_vd;
    logic                q_rd_hword;

    logic [PTR_W-1:0]    q_wptr;
    logic [PTR_W-1:0]    q_wptr_next;
    logic [PTR_W-1:0]    q_rptr;
    logic [PTR_W-1:0]    q_rptr_next;
    logic [PTR_W-1:0]    q_ocpd_next;

    half_t               q_data [Q_HALFS];
    logic                q_err  [Q_HALFS];
    half_t               q_data_head;
    half_t               q_data_next;
    logic                q_err_head;
    logic                q_err_next;

    logic                q_is_empty;
    logic                q_has_1_ocpd_hw;
    logic                q_head_is_rvi;
    logic [FREE_H_W-1:0] q_ocpd_h;
    logic [FREE_H_W-1:0] q_free_h_next;

    // --------------------
    // Parcel decoder
    // --------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            unaligned_ff <= 1'b0;
            straddle_ff  <= 1'b0;
        end else if (q.pc_new_req) begin
            unaligned_ff <= q.pc_new_half;
            straddle_ff  <= 1'b0;
        end else if (q.resp_vd) begin
            unaligned_ff <= 1'b0;                   // Only the first word is unaligned
            straddle_ff  <= straddle_next;
        end
    end

    assign hi_is_rvi = &q.rdata.half.hi[1:0];
    assign lo_is_rvi = &q.rdata.half.lo[1:0];

    always_comb begin
        instr_type = INSTR_NONE;
        if (q.resp_vd) begin
            if (unaligned_ff) begin
                instr_type = hi_is_rvi ? INSTR_RVI_LO_NV : INSTR_RVC_NV;
            end else if (straddle_ff) begin
                instr_type = hi_is_rvi ? INSTR_RVI_LO_RVI_HI : INSTR_RVC_RVI_HI;
            end else if (lo_is_rvi) begin
                instr_type = INSTR_RVI_HI_RVI_LO;
            end else begin
                instr_type = hi_is_rvi ? INSTR_RVI_LO_RVC : INSTR_RVC_RVC;
            end
        end
    end

    assign straddle_next = (instr_type == INSTR_RVI_LO_NV)
                         | (instr_type == INSTR_RVI_LO_RVI_HI)
                         | (instr_type == INSTR_RVI_LO_RVC);

    assign q_wr_en   = q.resp_vd & ~q.flush;
    assign q_wr_hi   = (instr_type == INSTR_RVC_NV) | (instr_type == INSTR_RVI_LO_NV);
    assign q_wr_full = (instr_type != INSTR_NONE) & ~q_wr_hi;

    // --------------------
    // Pointers
    // --------------------

    assign q_rd_vd    = idu_vd_o & idu_rdy_i;
    assign q_rd_hword = ~q_head_is_rvi | q_err_head;        // Faults leave as one parcel

    always_comb begin
        q_wptr_next = q_wptr;
        if (q.flush) begin
            q_wptr_next = '0;
        end else if (q_wr_en) begin
            q_wptr_next = q_wptr + (q_wr_full ? PTR_W'(2) : PTR_W'(1));
        end
    end

    always_comb begin
        q_rptr_next = q_rptr;
        if (q.flush) begin
            q_rptr_next = '0;
        end else if (q_rd_vd) begin
            q_rptr_next = q_rptr + (q_rd_hword ? PTR_W'(1) : PTR_W'(2));
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q_wptr <= '0;
            q_rptr <= '0;
        end else begin
            q_wptr <= q_wptr_next;
            q_rptr <= q_rptr_next;
        end
    end

    // --------------------
    // Storage
    // --------------------

    always_ff @(posedge clk) begin
        if (q_wr_en & q_wr_hi) begin
            q_data[ADR_W'(q_wptr)] <= q.rdata.half.hi;
            q_err [ADR_W'(q_wptr)] <= q.resp_er;
        end else if (q_wr_en & q_wr_full) begin
            q_data[ADR_W'(q_wptr)]        <= q.rdata.half.lo;
            q_err [ADR_W'(q_wptr)]        <= q.resp_er;
            q_data[ADR_W'(q_wptr + 1'b1)] <= q.rdata.half.hi;
            q_err [ADR_W'(q_wptr + 1'b1)] <= q.resp_er;
        end
    end

    assign q_data_head = q_data[ADR_W'(q_rptr)];
    assign q_data_next = q_data[ADR_W'(q_rptr + 1'b1)];
    assign q_err_head  = q_err [ADR_W'(q_rptr)];
    assign q_err_next  = q_err [ADR_W'(q_rptr + 1'b1)];

    // Status
    assign q_is_empty      = (q_rptr == q_wptr);
    assign q_ocpd_h        = FREE_H_W'(q_wptr - q_rptr);
    assign q_has_1_ocpd_hw = (q_ocpd_h == FREE_H_W'(1));
    assign q_head_is_rvi   = &q_data_head[1:0];

    assign q_ocpd_next   = q_wptr - q_rptr_next;
    assign q_free_h_next = FREE_H_W'(Q_HALFS) - FREE_H_W'(q_ocpd_next);
    assign q.free_words  = FREE_W_W'(q_free_h_next >> 1);   // Whole words only

    // --------------------
    // Decode side output
    // --------------------

    always_comb begin
        idu_vd_o         = 1'b0;
        idu_imem_err_o   = 1'b0;
        idu_err_rvi_hi_o = 1'b0;
        if (!q_is_empty) begin
            if (q_has_1_ocpd_hw) begin
                idu_vd_o       = ~q_head_is_rvi | q_err_head;   // Lone low half waits
                idu_imem_err_o = q_err_head;
            end else begin
                idu_vd_o         = 1'b1;
                idu_imem_err_o   = q_err_head | (q_head_is_rvi & q_err_next);
                idu_err_rvi_hi_o = ~q_err_head & q_head_is_rvi & q_err_next;
            end
        end
    end

    // Compressed parcels zero-extended
    assign idu_instr_o = q_rd_hword ? XLEN'(q_data_head) : {q_data_next, q_data_head};

endmodule : ifu_instr_queue

// File: rtl/ifu_fetch_ctrl.sv
/* Fetch FSM, word address register, pending and discard counters
   and the memory request outputs */

`timescale 1ns/100ps

module ifu_fetch_ctrl #(
    parameter int TXN_CNT_W = ifu_pkg::TXN_CNT_W_DEF
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     pipe_stop_fetch_i,     // Stop fetching
    input  logic                     exu_pc_new_req_i,      // Redirect
    input  logic [ifu_pkg::XLEN-1:0] exu_pc_new_i,          // Redirect target
    input  logic                     imem_ack_i,            // Request taken
    input  ifu_pkg::mem_resp_e       imem_resp_i,
    input  ifu_pkg::imem_word_u      imem_rdata_i,
    output logic                     imem_req_o,
    output logic [ifu_pkg::XLEN-1:0] imem_addr_o,
    ifu_queue_if.ctrl                q
);
    import ifu_pkg::*;

    typedef enum logic {
        FSM_IDLE,
        FSM_FETCH
    } fetch_fsm_e;

    fetch_fsm_e           fsm_ff;
    fetch_fsm_e           fsm_next;
    logic                 fsm_fetch;
    logic                 fetch_req;
    logic                 stop_req;

    logic                 resp_ok;
    logic                 resp_er;
    logic                 resp_received;
    logic                 resp_vd;
    logic                 resp_er_vd;
    logic                 handshake;

    logic [XLEN-1:2]      addr_ff;
    logic [XLEN-1:2]      addr_next;

    logic [TXN_CNT_W-1:0] pnd_cnt;
    logic [TXN_CNT_W-1:0] pnd_cnt_next;
    logic [TXN_CNT_W-1:0] vd_pnd_cnt;
    logic                 pnd_full;

    logic [TXN_CNT_W-1:0] discard_cnt;
    logic [TXN_CNT_W-1:0] discard_cnt_next;
    logic                 discard_upd;
    logic                 discard_req;

    logic [TXN_CNT_W:0]   free_words_ext;
    logic                 q_has_room;

    // --------------------
    // Response decode
    // --------------------

    assign resp_ok       = (imem_resp_i == MEM_RESP_RDY_OK);
    assign resp_er       = (imem_resp_i == MEM_RESP_RDY_ER);
    assign resp_received = resp_ok | resp_er;
    assign resp_vd       = resp_received & ~discard_req;    // Stale ones dropped here
    assign resp_er_vd    = resp_er & ~discard_req;
    assign handshake     = imem_req_o & imem_ack_i;

    // --------------------
    // FSM
    // --------------------

    assign fetch_req = exu_pc_new_req_i & ~pipe_stop_fetch_i;
    assign stop_req  = pipe_stop_fetch_i | (resp_er_vd & ~exu_pc_new_req_i);

    always_comb begin
        fsm_next = fsm_ff;
        case (fsm_ff)
            FSM_IDLE:  if (fetch_req) fsm_next = FSM_FETCH;
            FSM_FETCH: if (stop_req)  fsm_next = FSM_IDLE;
            default:   fsm_next = FSM_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fsm_ff <= FSM_IDLE;
        end else begin
            fsm_ff <= fsm_next;
        end
    end

    assign fsm_fetch = (fsm_ff == FSM_FETCH);

    // --------------------
    // Word address
    // --------------------

    // Skip the redirect word when it is taken in the same cycle
    assign addr_next = exu_pc_new_req_i ? exu_pc_new_i[XLEN-1:2] + (XLEN-2)'(handshake)
                                        : addr_ff + (XLEN-2)'(handshake);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_ff <= '0;
        end else if (exu_pc_new_req_i | handshake) begin
            addr_ff <= addr_next;
        end
    end

    // --------------------
    // Pending and discard
    // --------------------

    assign pnd_cnt_next = pnd_cnt + (TXN_CNT_W'(handshake) - TXN_CNT_W'(resp_received));
    assign pnd_full     = &pnd_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pnd_cnt <= '0;
        end else begin
            pnd_cnt <= pnd_cnt_next;
        end
    end

    assign discard_upd      = exu_pc_new_req_i | resp_er_vd | (resp_received & discard_req);
    assign discard_cnt_next = exu_pc_new_req_i ? pnd_cnt_next - TXN_CNT_W'(handshake)
                            : resp_er_vd       ? pnd_cnt_next       // Nothing after a fault
                                               : discard_cnt - 1'b1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            discard_cnt <= '0;
        end else if (discard_upd) begin
            discard_cnt <= discard_cnt_next;
        end
    end

    assign discard_req = |discard_cnt;
    assign vd_pnd_cnt  = pnd_cnt - discard_cnt;     // Responses that will land in the queue

    // --------------------
    // Memory request
    // --------------------

    assign free_words_ext = (TXN_CNT_W+1)'(q.free_words);
    assign q_has_room     = free_words_ext > {1'b0, vd_pnd_cnt};

    assign imem_req_o  = (exu_pc_new_req_i & ~pnd_full & ~pipe_stop_fetch_i)
                       | (fsm_fetch & ~pnd_full & q_has_room);
    assign imem_addr_o = exu_pc_new_req_i ? {exu_pc_new_i[XLEN-1:2], 2'b00}
                                          : {addr_ff, 2'b00};

    // Toward the queue
    assign q.resp_vd     = resp_vd;
    assign q.resp_er     = resp_er_vd;
    assign q.rdata       = imem_rdata_i;
    assign q.flush       = exu_pc_new_req_i | pipe_stop_fetch_i;
    assign q.pc_new_req  = exu_pc_new_req_i;
    assign q.pc_new_half = exu_pc_new_i[1];

endmodule : ifu_fetch_ctrl

// File: rtl/ifu_queue_if.sv
/* Link between the fetch controller and the halfword queue */

`timescale 1ns/100ps

interface ifu_queue_if #(
    parameter int Q_WORDS = ifu_pkg::Q_WORDS_DEF
);
    import ifu_pkg::*;

    localparam int FREE_W = $clog2(Q_WORDS + 1);

    logic              resp_vd;         // Accepted response, not discarded
    logic              resp_er;         // That response is an access fault
    imem_word_u        rdata;           // Response word
    logic              flush;           // New PC or stop
    logic              pc_new_req;      // New PC this cycle
    logic              pc_new_half;     // New PC bit 1
    logic [FREE_W-1:0] free_words;      // Free words after this cycle's read

    // Controller side
    modport ctrl (
        output resp_vd, resp_er, rdata, flush, pc_new_req, pc_new_half,
        input  free_words
    );

    // Queue side
    modport queue (
        input  resp_vd, resp_er, rdata, flush, pc_new_req, pc_new_half,
        output free_words
    );

endinterface : ifu_queue_if

// File: rtl/ifu_pkg.sv
/* Shared widths, queue defaults, memory response type and the
   fetch word union for the instruction fetch unit */

package ifu_pkg;

    // --------------------
    // Widths
    // --------------------

    localparam int XLEN   = 32;                 // PC, address and memory data
    localparam int HALF_W = 16;                 // One instruction parcel

    // --------------------
    // Default sizing
    // --------------------

    localparam int Q_WORDS_DEF   = 2;           // Queue depth in words
    localparam int TXN_CNT_W_DEF = 3;           // Pending and discard counters

    // --------------------
    // Types
    // --------------------

    // One 16-bit parcel
    typedef logic [HALF_W-1:0] half_t;

    // Word split into parcels, low parcel at the lower address
    typedef struct packed {
        half_t hi;                              // Bits 31:16
        half_t lo;                              // Bits 15:0
    } half_pair_t;

    // Fetched word seen either as one full instruction or as two parcels
    typedef union packed {
        logic [XLEN-1:0] instr;
        half_pair_t      half;
    } imem_word_u;

    // Memory response
    typedef enum logic [1:0] {
        MEM_RESP_NOTRDY = 2'b00,                // Nothing this cycle
        MEM_RESP_RDY_OK = 2'b01,                // Data valid
        MEM_RESP_RDY_ER = 2'b10                 // Access fault
    } mem_resp_e;

    // Parcel coding
    // Low bits 2'b11 mark a full 32-bit instruction
    // Any other value marks a compressed one

endpackage : ifu_pkg
